//--- src/rv32i_types_pkg.sv
package rv32i_types_pkg;

    // architectural widths
    localparam int unsigned xlen           = 32;
    localparam int unsigned order_width    = 64;
    localparam int unsigned reg_addr_width = 5;

    typedef logic [xlen-1:0]           word_t;
    typedef logic [xlen-1:0]           pc_t;
    typedef logic [order_width-1:0]    order_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        op_b_lui   = 7'b0110111,
        op_b_auipc = 7'b0010111,
        op_b_jal   = 7'b1101111,
        op_b_jalr  = 7'b1100111,
        op_b_br    = 7'b1100011,
        op_b_load  = 7'b0000011,
        op_b_store = 7'b0100011,
        op_b_imm   = 7'b0010011,
        op_b_reg   = 7'b0110011
    } rv32i_opcode_t;

    // funct3 for integer register and immediate ops
    typedef enum logic [2:0] {
        arith_f3_add  = 3'b000,
        arith_f3_sll  = 3'b001,
        arith_f3_slt  = 3'b010,
        arith_f3_sltu = 3'b011,
        arith_f3_xor  = 3'b100,
        arith_f3_sr   = 3'b101,
        arith_f3_or   = 3'b110,
        arith_f3_and  = 3'b111
    } arith_f3_t;

    typedef enum logic [2:0] {
        load_f3_lb  = 3'b000,
        load_f3_lh  = 3'b001,
        load_f3_lw  = 3'b010,
        load_f3_lbu = 3'b100,
        load_f3_lhu = 3'b101
    } load_f3_t;

    typedef enum logic [2:0] {
        store_f3_sb = 3'b000,
        store_f3_sh = 3'b001,
        store_f3_sw = 3'b010
    } store_f3_t;

    typedef enum logic [2:0] {
        branch_f3_beq  = 3'b000,
        branch_f3_bne  = 3'b001,
        branch_f3_blt  = 3'b100,
        branch_f3_bge  = 3'b101,
        branch_f3_bltu = 3'b110,
        branch_f3_bgeu = 3'b111
    } branch_f3_t;

    // funct7 picks sub/sra and the M extension
    typedef enum logic [6:0] {
        base    = 7'b0000000,
        variant = 7'b0100000,
        mult    = 7'b0000001
    } funct7_t;

endpackage

//--- src/decode_ctrl_pkg.sv
package decode_ctrl_pkg;

    // first program-order number after reset
    localparam rv32i_types_pkg::order_t order_reset_value = '0;

    // which functional unit class gets the instruction
    typedef enum logic [2:0] {
        none = 3'd0,
        alu  = 3'd1,
        mul  = 3'd2,
        br   = 3'd3,
        mem  = 3'd4
    } op_type_t;

    // low eight codes line up with funct3
    typedef enum logic [3:0] {
        alu_op_add  = 4'b0000,
        alu_op_sll  = 4'b0001,
        alu_op_slt  = 4'b0010,
        alu_op_sltu = 4'b0011,
        alu_op_xor  = 4'b0100,
        alu_op_srl  = 4'b0101,
        alu_op_or   = 4'b0110,
        alu_op_and  = 4'b0111,
        alu_op_sub  = 4'b1000,
        alu_op_sra  = 4'b1001,
        alu_op_none = 4'b1111
    } alu_ops_t;

    // M extension op, equal to funct3
    typedef enum logic [2:0] {
        mult_op_mul    = 3'b000,
        mult_op_mulh   = 3'b001,
        mult_op_mulhsu = 3'b010,
        mult_op_mulhu  = 3'b011,
        mult_op_div    = 3'b100,
        mult_op_divu   = 3'b101,
        mult_op_rem    = 3'b110,
        mult_op_remu   = 3'b111
    } mult_op_t;

    typedef enum logic [2:0] {
        mem_op_b    = 3'd0,
        mem_op_bu   = 3'd1,
        mem_op_h    = 3'd2,
        mem_op_hu   = 3'd3,
        mem_op_w    = 3'd4,
        mem_op_none = 3'd7
    } mem_op_t;

    // alu operand muxes
    typedef enum logic [1:0] {
        rs1_out = 2'd0,
        pc_out  = 2'd1,
        no_out  = 2'd2
    } alu_m1_sel_t;

    typedef enum logic {
        rs2_out = 1'b0,
        imm_out = 1'b1
    } alu_m2_sel_t;

    typedef logic [3:0] byte_mask_t;

endpackage

//--- src/if_id_reg.sv
module if_id_reg
import rv32i_types_pkg::*;
import decode_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   stall,
    input  logic   fetch_valid,
    input  word_t  fetch_inst,
    input  pc_t    fetch_pc,
    output logic   id_valid,
    output word_t  id_inst,
    output pc_t    id_pc,
    output order_t id_order
);

    // order number the next accepted instruction receives
    order_t next_order;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid   <= 1'b0;
            next_order <= order_reset_value;
        end else if (!stall) begin
            // a low fetch_valid lets a bubble in
            id_valid <= fetch_valid;
            if (fetch_valid) begin
                next_order <= next_order + order_t'(1);
            end
        end
    end

    // payload, meaningful only with id_valid
    always_ff @(posedge clk) begin
        if (!stall) begin
            id_inst  <= fetch_inst;
            id_pc    <= fetch_pc;
            id_order <= next_order;
        end
    end

endmodule

//--- src/decode.sv
module decode
import rv32i_types_pkg::*;
import decode_ctrl_pkg::*;
(
    input  logic        id_valid,
    input  word_t       id_inst,
    input  pc_t         id_pc,
    input  order_t      id_order,
    output logic        dec_valid,
    output word_t       dec_inst,
    output pc_t         dec_pc,
    output order_t      dec_order,
    output op_type_t    dec_op_type,
    output alu_ops_t    dec_aluop,
    output mult_op_t    dec_multop,
    output mem_op_t     dec_memop,
    output branch_f3_t  dec_brop,
    output reg_addr_t   dec_rs1_addr,
    output reg_addr_t   dec_rs2_addr,
    output reg_addr_t   dec_rd_addr,
    output logic        dec_use_rs1,
    output logic        dec_use_rs2,
    output logic        dec_regf_we,
    output word_t       dec_imm,
    output alu_m1_sel_t dec_alu_m1_sel,
    output alu_m2_sel_t dec_alu_m2_sel,
    output byte_mask_t  dec_mem_rmask,
    output byte_mask_t  dec_mem_wmask
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      i_imm;
    word_t      s_imm;
    word_t      b_imm;
    word_t      u_imm;
    word_t      j_imm;

    assign opcode = id_inst[6:0];
    assign funct3 = id_inst[14:12];
    assign funct7 = id_inst[31:25];

    // sign-extended immediates of each format
    assign i_imm = {{20{id_inst[31]}}, id_inst[31:20]};
    assign s_imm = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
    assign b_imm = {{19{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
                    id_inst[11:8], 1'b0};
    assign u_imm = {id_inst[31:12], 12'h000};
    assign j_imm = {{11{id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
                    id_inst[30:21], 1'b0};

    // tag fields pass straight through
    assign dec_valid = id_valid;
    assign dec_inst  = id_inst;
    assign dec_pc    = id_pc;
    assign dec_order = id_order;

    always_comb begin
        // inactive defaults, unknown opcodes keep these
        dec_op_type    = none;
        dec_aluop      = alu_op_none;
        dec_multop     = mult_op_mul;
        dec_memop      = mem_op_none;
        dec_brop       = branch_f3_beq;
        dec_rs1_addr   = id_inst[19:15];
        dec_rs2_addr   = id_inst[24:20];
        dec_rd_addr    = id_inst[11:7];
        dec_use_rs1    = 1'b0;
        dec_use_rs2    = 1'b0;
        dec_regf_we    = 1'b0;
        dec_imm        = '0;
        dec_alu_m1_sel = no_out;
        dec_alu_m2_sel = rs2_out;
        dec_mem_rmask  = 4'b0000;
        dec_mem_wmask  = 4'b0000;

        unique case (opcode)
            op_b_lui: begin
                dec_op_type    = alu;
                dec_aluop      = alu_op_add;
                dec_imm        = u_imm;
                dec_regf_we    = 1'b1;
                dec_alu_m1_sel = no_out;
                dec_alu_m2_sel = imm_out;
            end
            op_b_auipc: begin
                dec_op_type    = alu;
                dec_aluop      = alu_op_add;
                dec_imm        = u_imm;
                dec_regf_we    = 1'b1;
                dec_alu_m1_sel = pc_out;
                dec_alu_m2_sel = imm_out;
            end
            op_b_imm: begin
                dec_op_type    = alu;
                dec_imm        = i_imm;
                dec_regf_we    = 1'b1;
                dec_use_rs1    = 1'b1;
                dec_alu_m1_sel = rs1_out;
                dec_alu_m2_sel = imm_out;
                unique case (funct3)
                    arith_f3_slt:  dec_aluop = alu_op_slt;
                    arith_f3_sltu: dec_aluop = alu_op_sltu;
                    // srai carries the variant bit in the upper imm field
                    arith_f3_sr:   dec_aluop = (funct7 == variant) ? alu_op_sra : alu_op_srl;
                    default:       dec_aluop = alu_ops_t'({1'b0, funct3});
                endcase
            end
            op_b_reg: begin
                dec_op_type    = alu;
                dec_regf_we    = 1'b1;
                dec_use_rs1    = 1'b1;
                dec_use_rs2    = 1'b1;
                dec_alu_m1_sel = rs1_out;
                dec_alu_m2_sel = rs2_out;
                if (funct7 == mult) begin
                    // M extension goes to the multiplier
                    dec_op_type = mul;
                    dec_multop  = mult_op_t'(funct3);
                end else begin
                    unique case (funct3)
                        arith_f3_add: begin
                            unique case (funct7)
                                base:    dec_aluop = alu_op_add;
                                variant: dec_aluop = alu_op_sub;
                                default: dec_aluop = alu_op_none;
                            endcase
                        end
                        arith_f3_sr: begin
                            unique case (funct7)
                                base:    dec_aluop = alu_op_srl;
                                variant: dec_aluop = alu_op_sra;
                                default: dec_aluop = alu_op_none;
                            endcase
                        end
                        arith_f3_slt:  dec_aluop = alu_op_slt;
                        arith_f3_sltu: dec_aluop = alu_op_sltu;
                        default:       dec_aluop = alu_ops_t'({1'b0, funct3});
                    endcase
                end
            end
            op_b_jal: begin
                dec_op_type    = br;
                dec_imm        = j_imm;
                dec_regf_we    = 1'b1;
                dec_alu_m1_sel = pc_out;
                dec_alu_m2_sel = imm_out;
            end
            op_b_jalr: begin
                dec_op_type    = br;
                dec_imm        = i_imm;
                dec_regf_we    = 1'b1;
                dec_use_rs1    = 1'b1;
                dec_alu_m1_sel = rs1_out;
                dec_alu_m2_sel = imm_out;
            end
            op_b_br: begin
                // compare rs1 against rs2, no writeback
                dec_op_type    = br;
                dec_brop       = branch_f3_t'(funct3);
                dec_imm        = b_imm;
                dec_rd_addr    = '0;
                dec_use_rs1    = 1'b1;
                dec_use_rs2    = 1'b1;
                dec_alu_m1_sel = rs1_out;
                dec_alu_m2_sel = rs2_out;
            end
            op_b_load: begin
                dec_op_type    = mem;
                dec_imm        = i_imm;
                dec_rs2_addr   = '0;
                dec_regf_we    = 1'b1;
                dec_use_rs1    = 1'b1;
                dec_alu_m1_sel = rs1_out;
                dec_alu_m2_sel = imm_out;
                unique case (funct3)
                    load_f3_lb: begin
                        dec_memop     = mem_op_b;
                        dec_mem_rmask = 4'b0001;
                    end
                    load_f3_lbu: begin
                        dec_memop     = mem_op_bu;
                        dec_mem_rmask = 4'b0001;
                    end
                    load_f3_lh: begin
                        dec_memop     = mem_op_h;
                        dec_mem_rmask = 4'b0011;
                    end
                    load_f3_lhu: begin
                        dec_memop     = mem_op_hu;
                        dec_mem_rmask = 4'b0011;
                    end
                    load_f3_lw: begin
                        dec_memop     = mem_op_w;
                        dec_mem_rmask = 4'b1111;
                    end
                    default: dec_memop = mem_op_none;
                endcase
            end
            op_b_store: begin
                dec_op_type    = mem;
                dec_imm        = s_imm;
                dec_rd_addr    = '0;
                dec_use_rs1    = 1'b1;
                dec_use_rs2    = 1'b1;
                dec_alu_m1_sel = rs1_out;
                dec_alu_m2_sel = imm_out;
                unique case (funct3)
                    store_f3_sb: begin
                        dec_memop     = mem_op_b;
                        dec_mem_wmask = 4'b0001;
                    end
                    store_f3_sh: begin
                        dec_memop     = mem_op_h;
                        dec_mem_wmask = 4'b0011;
                    end
                    store_f3_sw: begin
                        dec_memop     = mem_op_w;
                        dec_mem_wmask = 4'b1111;
                    end
                    default: dec_memop = mem_op_none;
                endcase
            end
            default: begin
                dec_op_type = none;
            end
        endcase
    end

endmodule

//--- src/id_dis_reg.sv
module id_dis_reg
import rv32i_types_pkg::*;
import decode_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        dec_valid,
    input  word_t       dec_inst,
    input  pc_t         dec_pc,
    input  order_t      dec_order,
    input  op_type_t    dec_op_type,
    input  alu_ops_t    dec_aluop,
    input  mult_op_t    dec_multop,
    input  mem_op_t     dec_memop,
    input  branch_f3_t  dec_brop,
    input  reg_addr_t   dec_rs1_addr,
    input  reg_addr_t   dec_rs2_addr,
    input  reg_addr_t   dec_rd_addr,
    input  logic        dec_use_rs1,
    input  logic        dec_use_rs2,
    input  logic        dec_regf_we,
    input  word_t       dec_imm,
    input  alu_m1_sel_t dec_alu_m1_sel,
    input  alu_m2_sel_t dec_alu_m2_sel,
    input  byte_mask_t  dec_mem_rmask,
    input  byte_mask_t  dec_mem_wmask,
    output logic        dis_valid,
    output word_t       dis_inst,
    output pc_t         dis_pc,
    output order_t      dis_order,
    output op_type_t    dis_op_type,
    output alu_ops_t    dis_aluop,
    output mult_op_t    dis_multop,
    output mem_op_t     dis_memop,
    output branch_f3_t  dis_brop,
    output reg_addr_t   dis_rs1_addr,
    output reg_addr_t   dis_rs2_addr,
    output reg_addr_t   dis_rd_addr,
    output logic        dis_use_rs1,
    output logic        dis_use_rs2,
    output logic        dis_regf_we,
    output word_t       dis_imm,
    output alu_m1_sel_t dis_alu_m1_sel,
    output alu_m2_sel_t dis_alu_m2_sel,
    output byte_mask_t  dis_mem_rmask,
    output byte_mask_t  dis_mem_wmask
);

    // valid and the enables dispatch acts on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dis_valid     <= 1'b0;
            dis_op_type   <= none;
            dis_use_rs1   <= 1'b0;
            dis_use_rs2   <= 1'b0;
            dis_regf_we   <= 1'b0;
            dis_mem_rmask <= 4'b0000;
            dis_mem_wmask <= 4'b0000;
        end else if (!stall) begin
            dis_valid     <= dec_valid;
            dis_op_type   <= dec_op_type;
            dis_use_rs1   <= dec_use_rs1;
            dis_use_rs2   <= dec_use_rs2;
            dis_regf_we   <= dec_regf_we;
            dis_mem_rmask <= dec_mem_rmask;
            dis_mem_wmask <= dec_mem_wmask;
        end
    end

    // operand and tag payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            dis_inst       <= dec_inst;
            dis_pc         <= dec_pc;
            dis_order      <= dec_order;
            dis_aluop      <= dec_aluop;
            dis_multop     <= dec_multop;
            dis_memop      <= dec_memop;
            dis_brop       <= dec_brop;
            dis_rs1_addr   <= dec_rs1_addr;
            dis_rs2_addr   <= dec_rs2_addr;
            dis_rd_addr    <= dec_rd_addr;
            dis_imm        <= dec_imm;
            dis_alu_m1_sel <= dec_alu_m1_sel;
            dis_alu_m2_sel <= dec_alu_m2_sel;
        end
    end

endmodule

//--- src/decode_stage.sv
module decode_stage
import rv32i_types_pkg::*;
import decode_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        fetch_valid,
    input  word_t       fetch_inst,
    input  pc_t         fetch_pc,
    output logic        dis_valid,
    output word_t       dis_inst,
    output pc_t         dis_pc,
    output order_t      dis_order,
    output op_type_t    dis_op_type,
    output alu_ops_t    dis_aluop,
    output mult_op_t    dis_multop,
    output mem_op_t     dis_memop,
    output branch_f3_t  dis_brop,
    output reg_addr_t   dis_rs1_addr,
    output reg_addr_t   dis_rs2_addr,
    output reg_addr_t   dis_rd_addr,
    output logic        dis_use_rs1,
    output logic        dis_use_rs2,
    output logic        dis_regf_we,
    output word_t       dis_imm,
    output alu_m1_sel_t dis_alu_m1_sel,
    output alu_m2_sel_t dis_alu_m2_sel,
    output byte_mask_t  dis_mem_rmask,
    output byte_mask_t  dis_mem_wmask
);

    // if/id stage outputs
    logic        id_valid;
    word_t       id_inst;
    pc_t         id_pc;
    order_t      id_order;

    // decoded bundle ahead of the id/dispatch register
    logic        dec_valid;
    word_t       dec_inst;
    pc_t         dec_pc;
    order_t      dec_order;
    op_type_t    dec_op_type;
    alu_ops_t    dec_aluop;
    mult_op_t    dec_multop;
    mem_op_t     dec_memop;
    branch_f3_t  dec_brop;
    reg_addr_t   dec_rs1_addr;
    reg_addr_t   dec_rs2_addr;
    reg_addr_t   dec_rd_addr;
    logic        dec_use_rs1;
    logic        dec_use_rs2;
    logic        dec_regf_we;
    word_t       dec_imm;
    alu_m1_sel_t dec_alu_m1_sel;
    alu_m2_sel_t dec_alu_m2_sel;
    byte_mask_t  dec_mem_rmask;
    byte_mask_t  dec_mem_wmask;

    // port names line up across all three stages
    if_id_reg if_id_reg_inst (.*);

    decode decode_inst (.*);

    id_dis_reg id_dis_reg_inst (.*);

endmodule

//--- testbench/decode_vectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// columns: inst, stall, bubble, op_type, aluop, multop, memop, brop,
// rs1, rs2, rd, use_rs1, use_rs2, regf_we, imm, m1_sel, m2_sel, rmask, wmask
typedef struct packed {
    logic [31:0] inst;
    logic        stall_flag;
    logic        bubble;
    logic [2:0]  op_type;
    logic [3:0]  aluop;
    logic [2:0]  multop;
    logic [2:0]  memop;
    logic [2:0]  brop;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic        use_rs1;
    logic        use_rs2;
    logic        regf_we;
    logic [31:0] imm;
    logic [1:0]  m1_sel;
    logic        m2_sel;
    logic [3:0]  rmask;
    logic [3:0]  wmask;
} vec_t;

localparam int num_vectors = 31;

// registers x5 = rd, x6 = rs1, x7 = rs2 unless noted
vec_t vectors [num_vectors] = '{
    '{'hFFF30293,0,0,alu,alu_op_add,0,mem_op_none,0,6,31,5,1,0,1,'hFFFFFFFF,rs1_out,imm_out,0,0},
    '{'h06432293,0,0,alu,alu_op_slt,0,mem_op_none,0,6,4,5,1,0,1,'h00000064,rs1_out,imm_out,0,0},
    '{'h7FF33293,1,0,alu,alu_op_sltu,0,mem_op_none,0,6,31,5,1,0,1,'h000007FF,rs1_out,imm_out,0,0},
    '{'h40335293,0,0,alu,alu_op_sra,0,mem_op_none,0,6,3,5,1,0,1,'h00000403,rs1_out,imm_out,0,0},
    '{'h00335293,0,0,alu,alu_op_srl,0,mem_op_none,0,6,3,5,1,0,1,'h00000003,rs1_out,imm_out,0,0},
    '{'h007302B3,0,0,alu,alu_op_add,0,mem_op_none,0,6,7,5,1,1,1,'h0,rs1_out,rs2_out,0,0},
    '{'h407302B3,0,0,alu,alu_op_sub,0,mem_op_none,0,6,7,5,1,1,1,'h0,rs1_out,rs2_out,0,0},
    '{'h407352B3,0,0,alu,alu_op_sra,0,mem_op_none,0,6,7,5,1,1,1,'h0,rs1_out,rs2_out,0,0},
    '{'h007352B3,1,0,alu,alu_op_srl,0,mem_op_none,0,6,7,5,1,1,1,'h0,rs1_out,rs2_out,0,0},
    '{'h007342B3,0,0,alu,alu_op_xor,0,mem_op_none,0,6,7,5,1,1,1,'h0,rs1_out,rs2_out,0,0},
    // bubble, word is ignored
    '{'h00000000,0,1,none,alu_op_none,0,mem_op_none,0,0,0,0,0,0,0,'h0,no_out,rs2_out,0,0},
    '{'h027302B3,0,0,mul,alu_op_none,0,mem_op_none,0,6,7,5,1,1,1,'h0,rs1_out,rs2_out,0,0},
    '{'h027312B3,0,0,mul,alu_op_none,1,mem_op_none,0,6,7,5,1,1,1,'h0,rs1_out,rs2_out,0,0},
    '{'h027342B3,1,0,mul,alu_op_none,4,mem_op_none,0,6,7,5,1,1,1,'h0,rs1_out,rs2_out,0,0},
    '{'h027372B3,0,0,mul,alu_op_none,7,mem_op_none,0,6,7,5,1,1,1,'h0,rs1_out,rs2_out,0,0},
    // loads, rs2 forced to 0
    '{'h00830283,0,0,mem,alu_op_none,0,mem_op_b,0,6,0,5,1,0,1,'h00000008,rs1_out,imm_out,1,0},
    '{'h00834283,0,0,mem,alu_op_none,0,mem_op_bu,0,6,0,5,1,0,1,'h00000008,rs1_out,imm_out,1,0},
    '{'h00831283,0,0,mem,alu_op_none,0,mem_op_h,0,6,0,5,1,0,1,'h00000008,rs1_out,imm_out,3,0},
    '{'h00835283,1,0,mem,alu_op_none,0,mem_op_hu,0,6,0,5,1,0,1,'h00000008,rs1_out,imm_out,3,0},
    '{'hFFC32283,0,0,mem,alu_op_none,0,mem_op_w,0,6,0,5,1,0,1,'hFFFFFFFC,rs1_out,imm_out,15,0},
    // stores, rd forced to 0
    '{'h00730623,0,0,mem,alu_op_none,0,mem_op_b,0,6,7,0,1,1,0,'h0000000C,rs1_out,imm_out,0,1},
    '{'hFE731C23,0,0,mem,alu_op_none,0,mem_op_h,0,6,7,0,1,1,0,'hFFFFFFF8,rs1_out,imm_out,0,3},
    '{'h04732023,0,0,mem,alu_op_none,0,mem_op_w,0,6,7,0,1,1,0,'h00000040,rs1_out,imm_out,0,15},
    '{'h00000000,1,1,none,alu_op_none,0,mem_op_none,0,0,0,0,0,0,0,'h0,no_out,rs2_out,0,0},
    '{'h123452B7,0,0,alu,alu_op_add,0,mem_op_none,0,8,3,5,0,0,1,'h12345000,no_out,imm_out,0,0},
    '{'hFFFFF297,0,0,alu,alu_op_add,0,mem_op_none,0,31,31,5,0,0,1,'hFFFFF000,pc_out,imm_out,0,0},
    '{'hFF1FF0EF,0,0,br,alu_op_none,0,mem_op_none,0,31,17,1,0,0,1,'hFFFFFFF0,pc_out,imm_out,0,0},
    '{'h00008067,0,0,br,alu_op_none,0,mem_op_none,0,1,0,0,1,0,1,'h0,rs1_out,imm_out,0,0},
    '{'hFE730CE3,0,0,br,alu_op_none,0,mem_op_none,0,6,7,0,1,1,0,'hFFFFFFF8,rs1_out,rs2_out,0,0},
    '{'h00736863,1,0,br,alu_op_none,0,mem_op_none,6,6,7,0,1,1,0,'h00000010,rs1_out,rs2_out,0,0},
    // custom-0 opcode, not decoded
    '{'h0000000B,0,0,none,alu_op_none,0,mem_op_none,0,0,0,0,0,0,0,'h0,no_out,rs2_out,0,0}
};

`endif

//--- testbench/tb_decode_stage.sv
module tb_decode_stage
import rv32i_types_pkg::*;
import decode_ctrl_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    `include "decode_vectors.svh"

    localparam int cycle_limit = num_vectors * 4 + 50;

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        fetch_valid;
    word_t       fetch_inst;
    pc_t         fetch_pc;
    logic        dis_valid;
    word_t       dis_inst;
    pc_t         dis_pc;
    order_t      dis_order;
    op_type_t    dis_op_type;
    alu_ops_t    dis_aluop;
    mult_op_t    dis_multop;
    mem_op_t     dis_memop;
    branch_f3_t  dis_brop;
    reg_addr_t   dis_rs1_addr;
    reg_addr_t   dis_rs2_addr;
    reg_addr_t   dis_rd_addr;
    logic        dis_use_rs1;
    logic        dis_use_rs2;
    logic        dis_regf_we;
    word_t       dis_imm;
    alu_m1_sel_t dis_alu_m1_sel;
    alu_m2_sel_t dis_alu_m2_sel;
    byte_mask_t  dis_mem_rmask;
    byte_mask_t  dis_mem_wmask;

    typedef struct {
        vec_t   v;
        order_t order;
        pc_t    pc;
    } exp_t;

    exp_t   exp_q[$];
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     seed;
    order_t next_order;
    bit     loaded_last = 1'b0;
    bit     have_snap = 1'b0;
    logic   snap_valid;
    exp_t   snap;

    decode_stage decode_stage_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_field(input string name, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
        checks++;
        assert (act_val === exp_val) else begin
            $display("FAIL %0t %s expected %0h got %0h", $time, name, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic check_outputs(input exp_t e);
        check_field("dis_order", e.order, dis_order);
        check_field("dis_pc", e.pc, dis_pc);
        check_field("dis_inst", e.v.inst, dis_inst);
        check_field("dis_op_type", e.v.op_type, dis_op_type);
        check_field("dis_aluop", e.v.aluop, dis_aluop);
        check_field("dis_multop", e.v.multop, dis_multop);
        check_field("dis_memop", e.v.memop, dis_memop);
        check_field("dis_brop", e.v.brop, dis_brop);
        check_field("dis_rs1_addr", e.v.rs1, dis_rs1_addr);
        check_field("dis_rs2_addr", e.v.rs2, dis_rs2_addr);
        check_field("dis_rd_addr", e.v.rd, dis_rd_addr);
        check_field("dis_use_rs1", e.v.use_rs1, dis_use_rs1);
        check_field("dis_use_rs2", e.v.use_rs2, dis_use_rs2);
        check_field("dis_regf_we", e.v.regf_we, dis_regf_we);
        check_field("dis_imm", e.v.imm, dis_imm);
        check_field("dis_alu_m1_sel", e.v.m1_sel, dis_alu_m1_sel);
        check_field("dis_alu_m2_sel", e.v.m2_sel, dis_alu_m2_sel);
        check_field("dis_mem_rmask", e.v.rmask, dis_mem_rmask);
        check_field("dis_mem_wmask", e.v.wmask, dis_mem_wmask);
    endtask

    // present dispatch outputs in table form
    function automatic exp_t capture_outputs();
        exp_t c;
        c.v.inst       = dis_inst;
        c.v.stall_flag = 1'b0;
        c.v.bubble     = 1'b0;
        c.v.op_type    = dis_op_type;
        c.v.aluop      = dis_aluop;
        c.v.multop     = dis_multop;
        c.v.memop      = dis_memop;
        c.v.brop       = dis_brop;
        c.v.rs1        = dis_rs1_addr;
        c.v.rs2        = dis_rs2_addr;
        c.v.rd         = dis_rd_addr;
        c.v.use_rs1    = dis_use_rs1;
        c.v.use_rs2    = dis_use_rs2;
        c.v.regf_we    = dis_regf_we;
        c.v.imm        = dis_imm;
        c.v.m1_sel     = dis_alu_m1_sel;
        c.v.m2_sel     = dis_alu_m2_sel;
        c.v.rmask      = dis_mem_rmask;
        c.v.wmask      = dis_mem_wmask;
        c.order        = dis_order;
        c.pc           = dis_pc;
        return c;
    endfunction

    // table stall on the first attempt only and random stall on every attempt
    task automatic drive_entry(input int idx, input bit first);
        fetch_valid <= !vectors[idx].bubble;
        fetch_inst  <= vectors[idx].inst;
        fetch_pc    <= pc_t'(idx * 4);
        stall       <= (first && vectors[idx].stall_flag) || (($random(seed) & 3) == 0);
    endtask

    initial begin
        int   idx;
        bit   first;
        exp_t e;
        rst_n       = 1'b0;
        stall       = 1'b0;
        fetch_valid = 1'b0;
        fetch_inst  = '0;
        fetch_pc    = '0;
        seed        = 19;
        next_order  = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // outputs still hold their reset values here
        check_field("dis_valid", 0, dis_valid);
        check_field("dis_regf_we", 0, dis_regf_we);
        check_field("dis_use_rs1", 0, dis_use_rs1);
        check_field("dis_use_rs2", 0, dis_use_rs2);
        check_field("dis_mem_rmask", 0, dis_mem_rmask);
        check_field("dis_mem_wmask", 0, dis_mem_wmask);
        check_field("dis_op_type", none, dis_op_type);
        idx = 0;
        drive_entry(0, 1'b1);
        while (idx < num_vectors) begin
            @(posedge clk);
            first = 1'b0;
            if (!stall) begin
                // accepted at this edge
                if (fetch_valid) begin
                    e.v     = vectors[idx];
                    e.order = next_order;
                    e.pc    = pc_t'(idx * 4);
                    exp_q.push_back(e);
                    next_order++;
                end
                idx++;
                first = 1'b1;
            end
            if (idx < num_vectors) begin
                drive_entry(idx, first);
            end else begin
                fetch_valid <= 1'b0;
                stall       <= 1'b0;
            end
        end
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // scoreboard sees the values loaded at the previous edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (loaded_last && dis_valid) begin
                assert (exp_q.size() != 0) else begin
                    $display("unexpected instruction at dispatch at %0t", $time);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    check_outputs(exp_q.pop_front());
                end
            end
            if (have_snap && !loaded_last) begin
                check_field("held dis_valid", snap_valid, dis_valid);
                check_outputs(snap);
            end
            snap_valid  = dis_valid;
            snap        = capture_outputs();
            have_snap   = 1'b1;
            loaded_last = !stall;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout, run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

//--- flist.f
+incdir+testbench
src/rv32i_types_pkg.sv
src/decode_ctrl_pkg.sv
src/if_id_reg.sv
src/decode.sv
src/id_dis_reg.sv
src/decode_stage.sv
testbench/tb_decode_stage.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - src/rv32i_types_pkg.sv
  - src/decode_ctrl_pkg.sv
  - src/if_id_reg.sv
  - src/decode.sv
  - src/id_dis_reg.sv
  - src/decode_stage.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_decode_stage.sv
